// File: rtl/cdc_bridge_defs.svh
`ifndef CDC_BRIDGE_DEFS_SVH
`define CDC_BRIDGE_DEFS_SVH

// flops in each synchronizer chain.
`define CDC_STAGES 2

// data word carried by commands and responses.
`define DATA_W 32

// register address bits.
`define REG_ADDR_W 3

// implemented registers, upper addresses decode as bad.
`define REG_COUNT 6

`endif

// File: rtl/cdc_target_pkg.sv
`default_nettype none

`include "cdc_bridge_defs.svh"

package cdc_target_pkg;

   // completion status of one command.
   typedef enum logic {
      ST_OK       = 1'b0,
      ST_BAD_ADDR = 1'b1
   } status_t;

   // executor states.
   typedef enum logic {
      EX_IDLE = 1'b0,
      EX_RESP = 1'b1
   } exec_state_t;

   // register bank address.
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: rtl/cdc_xfer_pkg.sv
`default_nettype none

`include "cdc_bridge_defs.svh"

package cdc_xfer_pkg;

   // command opcodes.
   typedef enum logic [1:0] {
      OP_WRITE = 2'd0,
      OP_READ  = 2'd1,
      OP_ADD   = 2'd2
   } opcode_t;

   // request word, domain a to domain b.
   typedef struct packed {
      opcode_t                   opcode;
      cdc_target_pkg::reg_addr_t addr;
      logic [`DATA_W-1:0]        data;
   } cmd_t;

   // response word, domain b to domain a.
   typedef struct packed {
      cdc_target_pkg::status_t status;
      logic [`DATA_W-1:0]      data;
   } rsp_t;

endpackage

`default_nettype wire

// File: rtl/cdc_xfer_if.sv
`timescale 1ns/10ps
`default_nettype none

// one valid-ready channel with its payload.
interface cdc_xfer_if #(
   parameter int PAYLOAD_W = 32
) ();

   logic                 valid;
   logic                 ready;
   logic [PAYLOAD_W-1:0] payload;

   // producer side.
   modport src (
      output valid,
      output payload,
      input  ready
   );

   // consumer side.
   modport dst (
      input  valid,
      input  payload,
      output ready
   );

endinterface

`default_nettype wire

// File: rtl/cdc_sync_bit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module cdc_sync_bit #(
   parameter int   STAGES    = `CDC_STAGES,
   parameter logic RST_VALUE = 1'b0
) (
   input  wire  clk,
   input  wire  arst_n,
   input  logic d,
   output logic q
);

   // sync chain, stage 0 is the metastable one.
   logic [STAGES-1:0] sync_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= {STAGES{RST_VALUE}};
      end else begin
         sync_q[0] <= d;
         for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // last stage is safe to use.
   assign q = sync_q[STAGES-1];

endmodule

`default_nettype wire

// File: rtl/cdc_sync_hds.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module cdc_sync_hds (
   input  wire  clk_a,
   input  wire  arst_n,
   input  logic a_valid,
   output logic a_ready,
   input  wire  clk_b,
   output logic b_valid,
   input  logic b_ready
);

   logic flag_a;
   logic flag_b;
   // far flags seen in the local domain.
   logic b_flag_a;
   logic a_flag_b;

   // toggles once per a-side accept.
   always_ff @(posedge clk_a or negedge arst_n) begin
      if (!arst_n) begin
         flag_a <= 1'b0;
      end else if (a_valid && a_ready) begin
         flag_a <= ~flag_a;
      end
   end

   // toggles once per b-side accept.
   always_ff @(posedge clk_b or negedge arst_n) begin
      if (!arst_n) begin
         flag_b <= 1'b0;
      end else if (b_valid && b_ready) begin
         flag_b <= ~flag_b;
      end
   end

   // request flag into b.
   cdc_sync_bit #(
      .STAGES    (`CDC_STAGES),
      .RST_VALUE (1'b0)
   ) u_sync_a2b (
      .clk    (clk_b),
      .arst_n (arst_n),
      .d      (flag_a),
      .q      (b_flag_a)
   );

   // acknowledge flag into a.
   cdc_sync_bit #(
      .STAGES    (`CDC_STAGES),
      .RST_VALUE (1'b0)
   ) u_sync_b2a (
      .clk    (clk_a),
      .arst_n (arst_n),
      .d      (flag_b),
      .q      (a_flag_b)
   );

   // flags equal means nothing in flight.
   assign a_ready = (flag_a == a_flag_b);

   // flags differ means a transfer is waiting on b.
   assign b_valid = flag_b ^ b_flag_a;

endmodule

`default_nettype wire

// File: rtl/cdc_bus_bridge.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module cdc_bus_bridge #(
   parameter int PAYLOAD_W = `DATA_W
) (
   input wire      clk_a,
   input wire      clk_b,
   input wire      arst_n,
   cdc_xfer_if.dst src,
   cdc_xfer_if.src dst
);

   // word held across the boundary.
   logic [PAYLOAD_W-1:0] hold_q;
   logic                 src_accept;

   assign src_accept = src.valid && src.ready;

   // captured with the flag toggle.
   // stays put until the b side has accepted.
   always_ff @(posedge clk_a) begin
      if (src_accept) begin
         hold_q <= src.payload;
      end
   end

   // flag handshake, one word in flight.
   cdc_sync_hds u_hds (
      .clk_a   (clk_a),
      .arst_n  (arst_n),
      .a_valid (src.valid),
      .a_ready (src.ready),
      .clk_b   (clk_b),
      .b_valid (dst.valid),
      .b_ready (dst.ready)
   );

   // not synchronized, stable whenever dst.valid is high.
   assign dst.payload = hold_q;

endmodule

`default_nettype wire

// File: rtl/reg_exec.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module reg_exec (
   input wire      clk_b,
   input wire      arst_n,
   cdc_xfer_if.dst req,
   cdc_xfer_if.src rsp
);

   import cdc_xfer_pkg::*;
   import cdc_target_pkg::*;

   exec_state_t        state_q;
   logic [`DATA_W-1:0] regs_q [`REG_COUNT];
   cmd_t               cmd;
   rsp_t               rsp_q;
   logic               req_accept;
   logic               rsp_accept;
   logic               addr_ok;
   logic [`DATA_W-1:0] rd_data;
   logic [`DATA_W-1:0] result;

   assign cmd        = cmd_t'(req.payload);
   assign req_accept = req.valid && req.ready;
   assign rsp_accept = rsp.valid && rsp.ready;

   // only the low REG_COUNT addresses exist.
   assign addr_ok = (int'(cmd.addr) < `REG_COUNT);

   // register operand and result of the command.
   always_comb begin
      rd_data = addr_ok ? regs_q[cmd.addr] : '0;
      case (cmd.opcode)
         OP_WRITE: result = cmd.data;
         OP_READ:  result = rd_data;
         OP_ADD:   result = rd_data + cmd.data;
         default:  result = '0;
      endcase
   end

   // fsm and register bank.
   always_ff @(posedge clk_b or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= EX_IDLE;
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         if (req_accept) begin
            state_q <= EX_RESP;
            // reads and bad addresses leave the bank alone.
            if (addr_ok && (cmd.opcode != OP_READ)) begin
               regs_q[cmd.addr] <= result;
            end
         end else if (rsp_accept) begin
            state_q <= EX_IDLE;
         end
      end
   end

   // response word, held while waiting on rsp.ready.
   always_ff @(posedge clk_b) begin
      if (req_accept) begin
         rsp_q.status <= addr_ok ? ST_OK : ST_BAD_ADDR;
         rsp_q.data   <= addr_ok ? result : '0;
      end
   end

   // one command at a time.
   assign req.ready   = (state_q == EX_IDLE);
   assign rsp.valid   = (state_q == EX_RESP);
   assign rsp.payload = rsp_q;

endmodule

`default_nettype wire

// File: rtl/cdc_cmd_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module cdc_cmd_top (
   input  wire                       clk_a,
   input  wire                       clk_b,
   input  wire                       arst_n,
   input  logic                      req_valid,
   output logic                      req_ready,
   input  cdc_xfer_pkg::opcode_t     req_opcode,
   input  cdc_target_pkg::reg_addr_t req_addr,
   input  logic [`DATA_W-1:0]        req_data,
   output logic                      rsp_valid,
   input  logic                      rsp_ready,
   output cdc_target_pkg::status_t   rsp_status,
   output logic [`DATA_W-1:0]        rsp_data
);

   import cdc_xfer_pkg::*;

   localparam int CMD_W = $bits(cmd_t);
   localparam int RSP_W = $bits(rsp_t);

   cmd_t req_cmd;
   rsp_t rsp_word;

   // request, domain a side and domain b side.
   cdc_xfer_if #(.PAYLOAD_W(CMD_W)) req_a_if ();
   cdc_xfer_if #(.PAYLOAD_W(CMD_W)) req_b_if ();
   // response, domain b side and domain a side.
   cdc_xfer_if #(.PAYLOAD_W(RSP_W)) rsp_b_if ();
   cdc_xfer_if #(.PAYLOAD_W(RSP_W)) rsp_a_if ();

   // pack the request fields.
   assign req_cmd          = '{opcode: req_opcode, addr: req_addr, data: req_data};
   assign req_a_if.valid   = req_valid;
   assign req_a_if.payload = req_cmd;
   assign req_ready        = req_a_if.ready;

   // unpack the response fields.
   assign rsp_word       = rsp_t'(rsp_a_if.payload);
   assign rsp_valid      = rsp_a_if.valid;
   assign rsp_a_if.ready = rsp_ready;
   assign rsp_status     = rsp_word.status;
   assign rsp_data       = rsp_word.data;

   // clk_a to clk_b.
   cdc_bus_bridge #(
      .PAYLOAD_W (CMD_W)
   ) u_req_bridge (
      .clk_a  (clk_a),
      .clk_b  (clk_b),
      .arst_n (arst_n),
      .src    (req_a_if.dst),
      .dst    (req_b_if.src)
   );

   reg_exec u_reg_exec (
      .clk_b  (clk_b),
      .arst_n (arst_n),
      .req    (req_b_if.dst),
      .rsp    (rsp_b_if.src)
   );

   // clk_b to clk_a, source side runs on clk_b.
   cdc_bus_bridge #(
      .PAYLOAD_W (RSP_W)
   ) u_rsp_bridge (
      .clk_a  (clk_b),
      .clk_b  (clk_a),
      .arst_n (arst_n),
      .src    (rsp_b_if.dst),
      .dst    (rsp_a_if.src)
   );

endmodule

`default_nettype wire

// File: testbench/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

// free-running clock, starts low.
module clk_gen #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk
);

   initial clk = 1'b0;

   // half period per toggle.
   always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: testbench/cdc_cmd_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module cdc_cmd_properties (
   input wire  clk_a,
   input wire  arst_n,
   input logic a_valid,
   input logic a_ready,
   input wire  clk_b,
   input logic b_valid,
   input logic b_ready
);

   // clk_b edges since reset release, saturating.
   logic [3:0] b_cycles;

   always_ff @(posedge clk_b or negedge arst_n) begin
      if (!arst_n) begin
         b_cycles <= '0;
      end else if (b_cycles != 4'hf) begin
         b_cycles <= b_cycles + 4'd1;
      end
   end

   // a held-off source keeps asking.
   a_valid_held: assert property (
      @(posedge clk_a) disable iff (!arst_n)
      (a_valid && !a_ready) |=> a_valid
   ) else $error("a_valid dropped while a_ready was low");

   // a pending transfer on b stays up until taken.
   b_valid_held: assert property (
      @(posedge clk_b) disable iff (!arst_n)
      (b_valid && !b_ready) |=> b_valid
   ) else $error("b_valid dropped before b_ready");

   // the flag needs the whole chain to reach b.
   b_quiet_after_reset: assert property (
      @(posedge clk_b) disable iff (!arst_n)
      (int'(b_cycles) < `CDC_STAGES) |-> !b_valid
   ) else $error("b_valid rose faster than the synchronizer allows");

endmodule

// every handshake synchronizer gets its own checker.
bind cdc_sync_hds cdc_cmd_properties u_hds_props (
   .clk_a   (clk_a),
   .arst_n  (arst_n),
   .a_valid (a_valid),
   .a_ready (a_ready),
   .clk_b   (clk_b),
   .b_valid (b_valid),
   .b_ready (b_ready)
);

`default_nettype wire

// File: testbench/cdc_cmd_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cdc_bridge_defs.svh"

module cdc_cmd_tb;

   import cdc_xfer_pkg::*;
   import cdc_target_pkg::*;

   // generous bound for one command, includes response hold-off.
   localparam int unsigned CMD_BOUND_NS = 400;

   // one table row, stimulus plus expected response.
   typedef struct {
      opcode_t            op;
      reg_addr_t          addr;
      logic [`DATA_W-1:0] data;
      status_t            exp_status;
      logic [`DATA_W-1:0] exp_data;
   } vec_t;

   logic               clk_a;
   logic               clk_b;
   logic               arst_n;
   logic               req_valid;
   logic               req_ready;
   opcode_t            req_opcode;
   reg_addr_t          req_addr;
   logic [`DATA_W-1:0] req_data;
   logic               rsp_valid;
   logic               rsp_ready;
   status_t            rsp_status;
   logic [`DATA_W-1:0] rsp_data;

   vec_t               vectors [$];
   logic [`DATA_W-1:0] model_regs [`REG_COUNT];
   int                 sent_count = 0;
   int                 rsp_count = 0;
   int unsigned        timeout_ns = 0;
   bit                 table_ready = 1'b0;

   // 8 ns and 13 ns, edges rarely line up.
   clk_gen #(.PERIOD_NS(8.0)) u_clk_a (.clk(clk_a));
   clk_gen #(.PERIOD_NS(13.0)) u_clk_b (.clk(clk_b));

   cdc_cmd_top UUT (
      .clk_a      (clk_a),
      .clk_b      (clk_b),
      .arst_n     (arst_n),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_opcode (req_opcode),
      .req_addr   (req_addr),
      .req_data   (req_data),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_status (rsp_status),
      .rsp_data   (rsp_data)
   );

   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_status(input string name, input status_t got, input status_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %s, expected %s",
                  $time, name, got.name(), exp.name());
         abort_run();
      end
   endtask

   task automatic verify_data(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic expect_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   // register bank model.
   // bad address gives zero data and touches nothing.
   task automatic model_exec(input opcode_t op, input reg_addr_t addr,
                             input logic [`DATA_W-1:0] data, output status_t st,
                             output logic [`DATA_W-1:0] res);
      if (int'(addr) >= `REG_COUNT) begin
         st  = ST_BAD_ADDR;
         res = '0;
      end else begin
         st = ST_OK;
         case (op)
            OP_WRITE: begin
               model_regs[addr] = data;
               res = data;
            end
            OP_READ: res = model_regs[addr];
            OP_ADD: begin
               model_regs[addr] = model_regs[addr] + data;
               res = model_regs[addr];
            end
            default: res = '0;
         endcase
      end
   endtask

   // appends a row, expected columns from the model.
   task automatic add_vec(input opcode_t op, input reg_addr_t addr,
                          input logic [`DATA_W-1:0] data);
      vec_t v;
      v.op   = op;
      v.addr = addr;
      v.data = data;
      model_exec(op, addr, data, v.exp_status, v.exp_data);
      vectors.push_back(v);
   endtask

   task automatic build_table();
      foreach (model_regs[i]) model_regs[i] = '0;
      // write then read back.
      add_vec(OP_WRITE, 3'd0, 32'h1234_5678);
      add_vec(OP_READ,  3'd0, 32'h0);
      // accumulate, second add wraps.
      add_vec(OP_WRITE, 3'd3, 32'h0000_0010);
      add_vec(OP_ADD,   3'd3, 32'h0000_0005);
      add_vec(OP_ADD,   3'd3, 32'hffff_fff0);
      add_vec(OP_READ,  3'd3, 32'h0);
      // unimplemented addresses.
      add_vec(OP_WRITE, 3'd6, 32'hdead_beef);
      add_vec(OP_ADD,   3'd7, 32'h0000_0001);
      add_vec(OP_READ,  3'd7, 32'h0);
      add_vec(OP_WRITE, 3'd5, 32'ha5a5_a5a5);
      add_vec(OP_ADD,   3'd1, 32'h0000_0007);
      // whole bank, nothing disturbed by the bad ones.
      for (int a = 0; a < `REG_COUNT; a++) begin
         add_vec(OP_READ, reg_addr_t'(a), 32'h0);
      end
   endtask

   // request driver.
   initial begin
      void'($urandom(32'h11c));
      arst_n     = 1'b0;
      req_valid  = 1'b0;
      req_opcode = OP_WRITE;
      req_addr   = '0;
      req_data   = '0;
      build_table();
      timeout_ns  = (vectors.size() + 4) * CMD_BOUND_NS;
      table_ready = 1'b1;
      // release between edges of both clocks.
      repeat (5) @(posedge clk_a);
      #2;
      arst_n = 1'b1;
      @(posedge clk_a);
      expect_flag("req_ready", req_ready, 1'b1);
      expect_flag("rsp_valid", rsp_valid, 1'b0);
      foreach (vectors[i]) begin
         #1;
         req_valid  = 1'b1;
         req_opcode = vectors[i].op;
         req_addr   = vectors[i].addr;
         req_data   = vectors[i].data;
         @(posedge clk_a);
         while (!req_ready) @(posedge clk_a);
         sent_count++;
         #1;
         req_valid = 1'b0;
         // flag cannot come back faster than the sync chain.
         for (int k = 0; k < `CDC_STAGES; k++) begin
            @(posedge clk_a);
            expect_flag("req_ready", req_ready, 1'b0);
         end
         repeat ($urandom % 3) @(posedge clk_a);
      end
      wait (rsp_count == vectors.size());
      // any late duplicate shows up here.
      repeat (20) @(posedge clk_a);
      // both bridges drained, ready for the next command.
      expect_flag("rsp_valid", rsp_valid, 1'b0);
      expect_flag("req_ready", req_ready, 1'b1);
      $display("Simulation PASSED");
      $finish;
   end

   // random response back-pressure.
   initial begin
      rsp_ready = 1'b0;
      forever begin
         @(posedge clk_a);
         #1;
         rsp_ready = ($urandom % 3) != 0;
      end
   end

   // responses in order, one per accepted command.
   always @(posedge clk_a) begin
      if (arst_n && rsp_valid && rsp_ready) begin
         if (rsp_count >= sent_count) begin
            $display("Error: response at %0t with no command outstanding", $time);
            abort_run();
         end else begin
            compare_status("rsp_status", rsp_status, vectors[rsp_count].exp_status);
            verify_data("rsp_data", rsp_data, vectors[rsp_count].exp_data);
            rsp_count++;
         end
      end
   end

   // watchdog.
   initial begin
      wait (table_ready);
      #(timeout_ns);
      $display("Error: timeout after %0d ns with %0d of %0d responses",
               timeout_ns, rsp_count, vectors.size());
      abort_run();
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+rtl
rtl/cdc_target_pkg.sv
rtl/cdc_xfer_pkg.sv
rtl/cdc_xfer_if.sv
rtl/cdc_sync_bit.sv
rtl/cdc_sync_hds.sv
rtl/cdc_bus_bridge.sv
rtl/reg_exec.sv
rtl/cdc_cmd_top.sv
testbench/clk_gen.sv
testbench/cdc_cmd_properties.sv
testbench/cdc_cmd_tb.sv

// File: Makefile
TOP := cdc_cmd_tb
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f flist.f

run: build
	./$(OBJ)/V$(TOP) | awk '{ print } /^Simulation PASSED$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf $(OBJ)
